/* Makefile */
TOP := rv_issue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rv_issue_top.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing -f rv_issue_top.f --top-module rv_issue_top

clean:
	rm -rf obj_dir

/* dv/rv_issue_golden.txt */
# columns in hex: pc inst rd data jump target illegal
# one line per instruction in program order
00000100 123450b7 1 12345000 0 00000000 0
00000104 00001117 2 00001104 0 00000000 0
00000108 ffb00193 3 fffffffb 0 00000000 0
0000010c 7ff08213 4 123457ff 0 00000000 0
00000110 0f01c293 5 ffffff0b 0 00000000 0
00000114 0ff27313 6 000000ff 0 00000000 0
00000118 0011a393 7 00000001 0 00000000 0
0000011c 0011b413 8 00000000 0 00000000 0
00000120 00409493 9 23450000 0 00000000 0
00000124 0041d513 a 0fffffff 0 00000000 0
00000128 4021d593 b fffffffe 0 00000000 0
0000012c 00408633 c 2468a7ff 0 00000000 0
00000130 403606b3 d 2468a804 0 00000000 0
00000134 00c6c733 e 00000ffb 0 00000000 0
00000138 007717b3 f 00001ff6 0 00000000 0
0000013c 4071d2b3 5 fffffffd 0 00000000 0
00000140 00f1a333 6 00000001 0 00000000 0
00000144 00f1b433 8 00000000 0 00000000 0
00000148 0062e4b3 9 fffffffd 0 00000000 0
0000014c 00c4f533 a 2468a7fd 0 00000000 0
00000150 007655b3 b 123453ff 0 00000000 0
00000154 010000ef 1 00000158 1 00000164 0
00000158 00508167 2 0000015c 1 0000015c 0
0000015c 00208463 0 00000000 0 00000164 0
00000160 fe2098e3 0 00000000 1 00000150 0
00000164 0071c463 0 00000000 1 0000016c 0
00000168 fe71d8e3 0 00000000 0 00000158 0
0000016c 0071e463 0 00000000 0 00000174 0
00000170 0071f463 0 00000000 1 00000178 0
00000174 0000a283 0 00000000 0 00000000 1
00000178 05500013 0 00000055 0 00000000 0
0000017c 00500333 6 fffffffd 0 00000000 0
00000180 000003b3 7 00000000 0 00000000 0

/* dv/rv_issue_tb.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module rv_issue_tb;

  localparam int    CLK_HALF     = 50;
  localparam int    SAMPLE_DELAY = 25;
  localparam int    RESET_CYCLES = 10;
  localparam int    WAIT_LIMIT   = 200;
  localparam int    MAX_LINES    = 64;
  localparam string GOLDEN_FILE  = "dv/rv_issue_golden.txt";

  logic                  clk;
  logic                  rst;
  logic                  inst_valid;
  logic                  inst_ready;
  logic [31:0]           inst;
  logic [`RV_XLEN-1:0]   pc;
  logic                  result_valid;
  logic                  result_ready;
  logic [`RV_REG_W-1:0]  result_rd;
  logic [`RV_XLEN-1:0]   result_data;
  logic                  jump;
  logic [`RV_XLEN-1:0]   jump_target;
  logic                  illegal;

  // expected stream, one entry per golden line
  logic [31:0] gold_pc      [MAX_LINES];
  logic [31:0] gold_inst    [MAX_LINES];
  logic [31:0] gold_rd      [MAX_LINES];
  logic [31:0] gold_data    [MAX_LINES];
  logic [31:0] gold_jump    [MAX_LINES];
  logic [31:0] gold_target  [MAX_LINES];
  logic [31:0] gold_illegal [MAX_LINES];
  int          num_lines;
  logic [31:0] lcg_state;
  bit          failed;

  rv_issue_top rv_issue_top_i (
    .clk            (clk),
    .rst            (rst),
    .inst_valid_i   (inst_valid),
    .inst_ready_o   (inst_ready),
    .inst_i         (inst),
    .pc_i           (pc),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .result_rd_o    (result_rd),
    .result_data_o  (result_data),
    .jump_o         (jump),
    .jump_target_o  (jump_target),
    .illegal_o      (illegal)
  );

  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      abort_run($sformatf("Mismatch at %0d ns: %s expected %h got %h",
                          $time, name, expected, actual));
  endtask

  task automatic check_result(input int idx);
    check_field("result_rd_o", gold_rd[idx], 32'(result_rd));
    check_field("result_data_o", gold_data[idx], result_data);
    check_field("jump_o", gold_jump[idx], 32'(jump));
    check_field("jump_target_o", gold_target[idx], jump_target);
    check_field("illegal_o", gold_illegal[idx], 32'(illegal));
  endtask

  task automatic load_golden();
    int            fd;
    int            fields;
    bit            at_end;
    logic [1023:0] line_buf;
    logic [31:0]   v_pc;
    logic [31:0]   v_inst;
    logic [31:0]   v_rd;
    logic [31:0]   v_data;
    logic [31:0]   v_jump;
    logic [31:0]   v_target;
    logic [31:0]   v_illegal;
    num_lines = 0;
    at_end    = 1'b0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open golden file %s", GOLDEN_FILE));
    end
    while (!at_end) begin
      line_buf = '0;
      if ($fgets(line_buf, fd) == 0) begin
        at_end = 1'b1;
      end else begin
        // comment and blank lines match no fields
        fields = $sscanf(line_buf, "%h %h %h %h %h %h %h", v_pc, v_inst, v_rd,
                         v_data, v_jump, v_target, v_illegal);
        if (fields == 7) begin
          if (num_lines >= MAX_LINES) begin
            abort_run("golden file has more lines than the testbench can hold");
          end else begin
            gold_pc[num_lines]      = v_pc;
            gold_inst[num_lines]    = v_inst;
            gold_rd[num_lines]      = v_rd;
            gold_data[num_lines]    = v_data;
            gold_jump[num_lines]    = v_jump;
            gold_target[num_lines]  = v_target;
            gold_illegal[num_lines] = v_illegal;
            num_lines++;
          end
        end
      end
    end
    $fclose(fd);
    if (num_lines == 0) begin
      abort_run("golden file holds no instructions");
    end
  endtask

  // offer each instruction until decode takes it
  task automatic drive_program();
    int waited;
    bit accepted;
    for (int i = 0; i < num_lines; i++) begin
      @(negedge clk);
      inst_valid = 1'b1;
      inst       = gold_inst[i];
      pc         = gold_pc[i];
      accepted   = 1'b0;
      waited     = 0;
      while (!accepted) begin
        #(SAMPLE_DELAY);
        // transfer happens at the coming rising edge
        accepted = inst_ready;
        if (!accepted) begin
          waited++;
          if (waited > WAIT_LIMIT) begin
            abort_run($sformatf("timeout: inst_ready_o stayed low while offering pc %h",
                                gold_pc[i]));
          end else begin
            @(negedge clk);
          end
        end
      end
    end
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic collect_results();
    int idx;
    int idle;
    idx  = 0;
    idle = 0;
    while (idx < num_lines) begin
      @(negedge clk);
      lcg_state    = lcg_next(lcg_state);
      // about one cycle in four holds the result back
      result_ready = (lcg_state[30:29] != 2'b00);
      #(SAMPLE_DELAY);
      if (result_valid && result_ready) begin
        check_result(idx);
        idx++;
        idle = 0;
      end else if (idle >= WAIT_LIMIT) begin
        abort_run($sformatf("timeout: no result arrived for pc %h", gold_pc[idx]));
      end else begin
        idle++;
      end
    end
    // nothing may follow the last result
    @(negedge clk);
    result_ready = 1'b1;
    #(SAMPLE_DELAY);
    assert (!result_valid) else
      abort_run("an extra result appeared after the last expected one");
  endtask

  initial begin
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    pc           = '0;
    result_ready = 1'b0;
    failed       = 1'b0;
    lcg_state    = 32'd96186;
    load_golden();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #(SAMPLE_DELAY);
    check_field("result_valid_o", 32'd0, 32'(result_valid));
    check_field("inst_ready_o", 32'd1, 32'(inst_ready));
    fork
      drive_program();
      collect_results();
    join
    if (!failed) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* rv_issue_top.f */
+incdir+source
source/rv_issue_pkg.sv
source/issue_if.sv
source/reg_file.sv
source/scoreboard.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_issue_top.sv
dv/rv_issue_tb.sv

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  output logic [`RV_REG_W-1:0]  rs1_o,
  output logic [`RV_REG_W-1:0]  rs2_o,
  input  logic [`RV_NREG-1:0]   busy_i,
  input  logic                  wb_en_i,
  input  logic [`RV_REG_W-1:0]  wb_rd_i,
  input  logic [`RV_XLEN-1:0]   wb_data_i,
  issue_if.src                  issue_o
);

  logic                     valid_q;
  logic [31:0]              inst_q;
  logic [`RV_XLEN-1:0]      pc_q;
  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic                     funct7_b5;
  logic [`RV_REG_W-1:0]     rs1;
  logic [`RV_REG_W-1:0]     rs2;
  logic [`RV_REG_W-1:0]     rd;
  logic [`RV_XLEN-1:0]      imm_i;
  logic [`RV_XLEN-1:0]      imm_b;
  logic [`RV_XLEN-1:0]      imm_u;
  logic [`RV_XLEN-1:0]      imm_j;
  logic                     fwd1;
  logic                     fwd2;
  logic [`RV_XLEN-1:0]      src1;
  logic [`RV_XLEN-1:0]      src2;
  logic                     uses_rs1;
  logic                     uses_rs2;
  logic                     hazard;
  logic                     issue_fire;
  rv_issue_pkg::uop_kind_e  kind_d;
  rv_issue_pkg::alu_op_e    alu_op_d;
  logic [`RV_XLEN-1:0]      op1_d;
  logic [`RV_XLEN-1:0]      op2_d;
  logic [`RV_XLEN-1:0]      imm_d;
  logic                     wb_en_d;

  // instruction latch, one entry
  assign issue_fire   = issue_o.valid && issue_o.ready;
  assign inst_ready_o = !valid_q || issue_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // fields, RV32E uses the low 4 bits of each register index
  assign opcode    = inst_q[6:0];
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];
  assign rd        = inst_q[7 +: `RV_REG_W];
  assign rs1       = inst_q[15 +: `RV_REG_W];
  assign rs2       = inst_q[20 +: `RV_REG_W];

  assign imm_i = {{(`RV_XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{(`RV_XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                  inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                  inst_q[30:21], 1'b0};

  // bypass a writeback landing this cycle
  assign rs1_o = rs1;
  assign rs2_o = rs2;
  assign fwd1  = wb_en_i && (wb_rd_i == rs1) && (rs1 != '0);
  assign fwd2  = wb_en_i && (wb_rd_i == rs2) && (rs2 != '0);
  assign src1  = fwd1 ? wb_data_i : rdata1_i;
  assign src2  = fwd2 ? wb_data_i : rdata2_i;

  assign hazard = valid_q && (
    (uses_rs1 && (rs1 != '0) && busy_i[rs1] && !fwd1) ||
    (uses_rs2 && (rs2 != '0) && busy_i[rs2] && !fwd2));

  always_comb begin
    kind_d   = rv_issue_pkg::UOP_ILLEGAL;
    alu_op_d = rv_issue_pkg::ALU_ADD;
    op1_d    = '0;
    op2_d    = '0;
    imm_d    = '0;
    wb_en_d  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      rv_issue_pkg::OPC_LUI: begin
        kind_d  = rv_issue_pkg::UOP_ALU;
        op2_d   = imm_u;
        imm_d   = imm_u;
        wb_en_d = 1'b1;
      end
      rv_issue_pkg::OPC_AUIPC: begin
        kind_d  = rv_issue_pkg::UOP_ALU;
        op1_d   = pc_q;
        op2_d   = imm_u;
        imm_d   = imm_u;
        wb_en_d = 1'b1;
      end
      // link value is pc + 4, jump base in op1
      rv_issue_pkg::OPC_JAL: begin
        kind_d  = rv_issue_pkg::UOP_JUMP;
        op1_d   = pc_q;
        op2_d   = `RV_XLEN'd4;
        imm_d   = imm_j;
        wb_en_d = 1'b1;
      end
      rv_issue_pkg::OPC_JALR: begin
        kind_d   = rv_issue_pkg::UOP_JUMP;
        op1_d    = src1;
        op2_d    = `RV_XLEN'd4;
        imm_d    = imm_i;
        wb_en_d  = 1'b1;
        uses_rs1 = 1'b1;
      end
      rv_issue_pkg::OPC_BRANCH: begin
        kind_d   = rv_issue_pkg::UOP_BRANCH;
        op1_d    = src1;
        op2_d    = src2;
        imm_d    = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_issue_pkg::OPC_OP_IMM: begin
        kind_d   = rv_issue_pkg::UOP_ALU;
        // funct7[5] only selects SRAI, for other funct3 it is immediate
        alu_op_d = rv_issue_pkg::alu_op_e'({(funct3 == 3'b101) && funct7_b5, funct3});
        op1_d    = src1;
        op2_d    = imm_i;
        imm_d    = imm_i;
        wb_en_d  = 1'b1;
        uses_rs1 = 1'b1;
      end
      rv_issue_pkg::OPC_OP: begin
        kind_d   = rv_issue_pkg::UOP_ALU;
        alu_op_d = rv_issue_pkg::alu_op_e'({funct7_b5, funct3});
        op1_d    = src1;
        op2_d    = src2;
        wb_en_d  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: begin
        kind_d = rv_issue_pkg::UOP_ILLEGAL;
      end
    endcase
  end

  assign issue_o.valid   = valid_q && !hazard;
  assign issue_o.kind    = kind_d;
  assign issue_o.alu_op  = alu_op_d;
  assign issue_o.br_cond = rv_issue_pkg::br_cond_e'(funct3);
  assign issue_o.op1     = op1_d;
  assign issue_o.op2     = op2_d;
  assign issue_o.imm     = imm_d;
  assign issue_o.pc      = pc_q;
  assign issue_o.rd      = rd;
  assign issue_o.wb_en   = wb_en_d;

  issue_hold_a: assert property (@(posedge clk) disable iff (rst)
    issue_o.valid && !issue_o.ready |=> issue_o.valid && $stable(issue_o.pc) &&
      $stable(issue_o.op1) && $stable(issue_o.op2) && $stable(issue_o.kind));

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  issue_if.dst                  issue_i,
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output logic [`RV_REG_W-1:0]  result_rd_o,
  output logic [`RV_XLEN-1:0]   result_data_o,
  output logic                  jump_o,
  output logic [`RV_XLEN-1:0]   jump_target_o,
  output logic                  illegal_o,
  output logic                  wb_en_o,
  output logic [`RV_REG_W-1:0]  wb_rd_o,
  output logic [`RV_XLEN-1:0]   wb_data_o
);

  logic                   slot_valid;
  logic [`RV_REG_W-1:0]   slot_rd;
  logic [`RV_XLEN-1:0]    slot_data;
  logic                   slot_jump;
  logic [`RV_XLEN-1:0]    slot_target;
  logic                   slot_illegal;
  logic                   slot_wb;
  logic                   fire;
  logic                   is_jump;
  logic                   is_branch;
  logic [`RV_XLEN-1:0]    alu_a;
  logic [`RV_XLEN-1:0]    alu_res;
  logic                   taken;
  logic [`RV_XLEN-1:0]    jalr_sum;
  logic [`RV_XLEN-1:0]    target;

  assign is_jump   = issue_i.kind == rv_issue_pkg::UOP_JUMP;
  assign is_branch = issue_i.kind == rv_issue_pkg::UOP_BRANCH;

  // jumps link pc + op2, op2 is 4 there
  assign alu_a = is_jump ? issue_i.pc : issue_i.op1;

  always_comb begin
    case (issue_i.alu_op)
      rv_issue_pkg::ALU_ADD:  alu_res = alu_a + issue_i.op2;
      rv_issue_pkg::ALU_SUB:  alu_res = alu_a - issue_i.op2;
      rv_issue_pkg::ALU_SLL:  alu_res = alu_a << issue_i.op2[4:0];
      rv_issue_pkg::ALU_SLT:  alu_res = {31'b0, $signed(alu_a) < $signed(issue_i.op2)};
      rv_issue_pkg::ALU_SLTU: alu_res = {31'b0, alu_a < issue_i.op2};
      rv_issue_pkg::ALU_XOR:  alu_res = alu_a ^ issue_i.op2;
      rv_issue_pkg::ALU_SRL:  alu_res = alu_a >> issue_i.op2[4:0];
      rv_issue_pkg::ALU_SRA:  alu_res = $unsigned($signed(alu_a) >>> issue_i.op2[4:0]);
      rv_issue_pkg::ALU_OR:   alu_res = alu_a | issue_i.op2;
      rv_issue_pkg::ALU_AND:  alu_res = alu_a & issue_i.op2;
      default:                alu_res = '0;
    endcase
  end

  always_comb begin
    case (issue_i.br_cond)
      rv_issue_pkg::BR_BEQ:  taken = issue_i.op1 == issue_i.op2;
      rv_issue_pkg::BR_BNE:  taken = issue_i.op1 != issue_i.op2;
      rv_issue_pkg::BR_BLT:  taken = $signed(issue_i.op1) < $signed(issue_i.op2);
      rv_issue_pkg::BR_BGE:  taken = $signed(issue_i.op1) >= $signed(issue_i.op2);
      rv_issue_pkg::BR_BLTU: taken = issue_i.op1 < issue_i.op2;
      rv_issue_pkg::BR_BGEU: taken = issue_i.op1 >= issue_i.op2;
      default:               taken = 1'b0;
    endcase
  end

  // branch off pc, jumps off op1 with bit 0 dropped
  assign jalr_sum = issue_i.op1 + issue_i.imm;
  assign target   = is_branch ? issue_i.pc + issue_i.imm :
                    is_jump   ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : '0;

  // slot accepts when empty or draining
  assign issue_i.ready = !slot_valid || result_ready_i;
  assign fire          = issue_i.valid && issue_i.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= 1'b0;
    end else if (fire) begin
      slot_valid <= 1'b1;
    end else if (result_ready_i) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      slot_rd      <= issue_i.wb_en ? issue_i.rd : '0;
      slot_data    <= issue_i.wb_en ? alu_res : '0;
      slot_jump    <= is_jump || (is_branch && taken);
      slot_target  <= target;
      slot_illegal <= issue_i.kind == rv_issue_pkg::UOP_ILLEGAL;
      slot_wb      <= issue_i.wb_en;
    end
  end

  assign result_valid_o = slot_valid;
  assign result_rd_o    = slot_rd;
  assign result_data_o  = slot_data;
  assign jump_o         = slot_jump;
  assign jump_target_o  = slot_target;
  assign illegal_o      = slot_illegal;

  // writeback on the accepted result
  assign wb_en_o   = slot_valid && result_ready_i && slot_wb;
  assign wb_rd_o   = slot_rd;
  assign wb_data_o = slot_data;

  slot_hold_a: assert property (@(posedge clk) disable iff (rst)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_rd_o) &&
      $stable(result_data_o) && $stable(jump_o) && $stable(jump_target_o) &&
      $stable(illegal_o));

endmodule

/* source/issue_if.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

interface issue_if;

  logic                     valid;
  logic                     ready;
  rv_issue_pkg::uop_kind_e  kind;
  rv_issue_pkg::alu_op_e    alu_op;
  rv_issue_pkg::br_cond_e   br_cond;
  logic [`RV_XLEN-1:0]      op1;
  logic [`RV_XLEN-1:0]      op2;
  logic [`RV_XLEN-1:0]      imm;
  logic [`RV_XLEN-1:0]      pc;
  logic [`RV_REG_W-1:0]     rd;
  logic                     wb_en;

  // decode side
  modport src (
    output valid, kind, alu_op, br_cond, op1, op2, imm, pc, rd, wb_en,
    input  ready
  );

  // execute side
  modport dst (
    input  valid, kind, alu_op, br_cond, op1, op2, imm, pc, rd, wb_en,
    output ready
  );

endinterface

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_W-1:0]  rs1_i,
  input  logic [`RV_REG_W-1:0]  rs2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  input  logic                  wen_i,
  input  logic [`RV_REG_W-1:0]  waddr_i,
  input  logic [`RV_XLEN-1:0]   wdata_i
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (waddr_i != '0)) begin
      // x0 is hardwired, drop writes to it
      regs[waddr_i] <= wdata_i;
    end
  end

  // async read, x0 forced to zero
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* source/rv_issue_pkg.sv */
package rv_issue_pkg;

  // major opcodes handled by decode
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // branch funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

  // what execute does with an issued instruction
  typedef enum logic [1:0] {
    UOP_ALU     = 2'b00,
    UOP_JUMP    = 2'b01,
    UOP_BRANCH  = 2'b10,
    UOP_ILLEGAL = 2'b11
  } uop_kind_e;

endpackage

/* source/rv_issue_settings.svh */
`ifndef RV_ISSUE_SETTINGS_SVH
`define RV_ISSUE_SETTINGS_SVH

// data and pc width
`define RV_XLEN 32

// RV32E register file size
`define RV_NREG 16

// register index width, log2 of RV_NREG
`define RV_REG_W 4

`endif

/* source/rv_issue_top.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module rv_issue_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output logic [`RV_REG_W-1:0]  result_rd_o,
  output logic [`RV_XLEN-1:0]   result_data_o,
  output logic                  jump_o,
  output logic [`RV_XLEN-1:0]   jump_target_o,
  output logic                  illegal_o
);

  logic [`RV_REG_W-1:0]  rs1;
  logic [`RV_REG_W-1:0]  rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic [`RV_NREG-1:0]   busy;
  logic                  wb_en;
  logic [`RV_REG_W-1:0]  wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;
  logic                  sb_issue;

  issue_if issue_bus ();

  // mark rd busy when a writing instruction moves to execute
  assign sb_issue = issue_bus.valid && issue_bus.ready && issue_bus.wb_en;

  decode_stage decode_stage_i (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .busy_i       (busy),
    .wb_en_i      (wb_en),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .issue_o      (issue_bus.src)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wen_i    (wb_en),
    .waddr_i  (wb_rd),
    .wdata_i  (wb_data)
  );

  scoreboard scoreboard_i (
    .clk        (clk),
    .rst        (rst),
    .issue_i    (sb_issue),
    .issue_rd_i (issue_bus.rd),
    .clear_i    (wb_en),
    .clear_rd_i (wb_rd),
    .busy_o     (busy)
  );

  execute_stage execute_stage_i (
    .clk            (clk),
    .rst            (rst),
    .issue_i        (issue_bus.dst),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .jump_o         (jump_o),
    .jump_target_o  (jump_target_o),
    .illegal_o      (illegal_o),
    .wb_en_o        (wb_en),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data)
  );

endmodule

/* source/scoreboard.sv */
`timescale 1ns/1ps
`include "rv_issue_settings.svh"

module scoreboard (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_i,
  input  logic [`RV_REG_W-1:0]  issue_rd_i,
  input  logic                  clear_i,
  input  logic [`RV_REG_W-1:0]  clear_rd_i,
  output logic [`RV_NREG-1:0]   busy_o
);

  logic [`RV_NREG-1:0] busy_q;
  logic [`RV_NREG-1:0] busy_d;

  always_comb begin
    busy_d = busy_q;
    // clear first so a same-cycle set on that register wins
    if (clear_i) begin
      busy_d[clear_rd_i] = 1'b0;
    end
    // x0 never has a pending write
    if (issue_i && (issue_rd_i != '0)) begin
      busy_d[issue_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  assign busy_o = busy_q;

  x0_never_busy_a: assert property (@(posedge clk) disable iff (rst)
    !busy_o[0]);

endmodule
